// File: rtl/c2i_pkg.sv
package c2i_pkg;

   // address width shared by pcx and ucb packets
   localparam int ADDR_W = 40;

   // pcx request type from the crossbar
   typedef enum logic [1:0] {
      PCX_LOAD  = 2'b00,
      PCX_IFILL = 2'b01,
      PCX_STORE = 2'b10,
      PCX_REPLY = 2'b11   // reply forwarded to tap
   } pcx_rq_e;

   // ucb packet type, codes follow the io bus encoding
   typedef enum logic [3:0] {
      UCB_READ_NACK  = 4'b0000,
      UCB_READ_ACK   = 4'b0001,
      UCB_READ_REQ   = 4'b0100,
      UCB_WRITE_REQ  = 4'b0101,
      UCB_IFILL_REQ  = 4'b0110,
      UCB_IFILL_NACK = 4'b0111
   } ucb_type_e;

   // ucb buffer id
   typedef enum logic [1:0] {
      UCB_BID_CMP = 2'b00,   // cpu side
      UCB_BID_TAP = 2'b01    // debug port
   } ucb_bid_e;

   // cpu request as it sits in the cpu buffer
   typedef struct packed {
      pcx_rq_e           rq;
      logic [2:0]        cpu_id;
      logic [1:0]        thr_id;
      logic              blk;      // block store flag
      logic [2:0]        size;
      logic [ADDR_W-1:0] addr;
      logic [63:0]       data;
   } pcx_pkt_t;

   // ucb packet with one 64 bit payload word
   typedef struct packed {
      logic [3:0]        pkt_type;
      logic [5:0]        thr_id;   // {0, cpu, thread}
      logic [1:0]        buf_id;
      logic [2:0]        size;
      logic [ADDR_W-1:0] addr;
      logic [63:0]       data;
   } ucb_pkt_t;

   // no-payload nack
   typedef struct packed {
      logic [3:0] pkt_type;
      logic [5:0] thr_id;
      logic [1:0] buf_id;
   } ucb_nack_t;

   // store ack back toward the cpu
   typedef struct packed {
      logic [7:0] cpu_mask;   // one-hot on cpu_id
      logic [2:0] cpu_id;
      logic [1:0] thr_id;
      logic       blk;        // reflected from the store
      logic       valid;
   } cpx_ack_t;

   localparam int PCX_W = $bits(pcx_pkt_t);
   localparam int UCB_W = $bits(ucb_pkt_t);
   localparam int ACK_W = $bits(cpx_ack_t);

   // mapped io window, both bounds inclusive
   localparam logic [ADDR_W-1:0] IO_WIN_LO = 40'h80_0000_0000;
   localparam logic [ADDR_W-1:0] IO_WIN_HI = 40'hbf_ffff_ffff;

   localparam int CPU_BUF_DEPTH = 4;
   localparam int ACK_BUF_DEPTH = 4;

   // slow control fsm
   typedef enum logic [2:0] {
      S_IDLE  = 3'd0,
      S_TAP   = 3'd1,   // tap packet on ucb
      S_LOAD  = 3'd2,   // pop cpu buffer head
      S_ISSUE = 3'd3,   // send converted packet
      S_ACK   = 3'd4    // push store ack
   } sctrl_state_e;

endpackage

// File: rtl/c2i_fifo.sv
`timescale 1ns/10ps

module c2i_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             in_valid,
   output logic             in_ready,
   input  logic [WIDTH-1:0] in_data,
   output logic             out_valid,
   input  logic             out_ready,
   output logic [WIDTH-1:0] out_data
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];   // storage, no reset
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [CNT_W-1:0] count, count_nxt;
   logic             push, pop;

   assign in_ready = (count != CNT_W'(DEPTH));   // full drops ready
   assign push     = in_valid && in_ready;
   assign pop      = out_valid && out_ready;
   assign out_data = mem[rd_ptr];

   always_comb begin
      count_nxt = count;
      if (push && !pop)
         count_nxt = count + 1'b1;
      else if (pop && !push)
         count_nxt = count - 1'b1;
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         out_valid <= 1'b0;
      end else begin
         if (push)   // wrap at depth
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count     <= count_nxt;
         out_valid <= (count_nxt != '0);   // word visible one cycle after push
      end
   end

endmodule

// File: rtl/c2i_sdp.sv
`timescale 1ns/10ps

module c2i_sdp (
   input  logic                         clk,
   input  c2i_pkg::pcx_pkt_t            cpu_buf_dout,
   input  logic                         cpu_buf_rd,
   input  c2i_pkg::ucb_pkt_t            tap_packet,
   input  logic                         tap_sel,
   input  logic                         cpu_packet_is_req,
   input  c2i_pkg::ucb_type_e           cpu_packet_type,
   output c2i_pkg::pcx_rq_e             pcx_rq,
   output c2i_pkg::ucb_pkt_t            c2i_packet,
   output logic [c2i_pkg::ADDR_W-1:0]   c2i_packet_addr,
   output c2i_pkg::ucb_nack_t           c2i_rd_nack_packet,
   output c2i_pkg::cpx_ack_t            wr_ack_packet
);

   import c2i_pkg::*;

   pcx_pkt_t pcx_q;        // captured cpu buffer head
   ucb_pkt_t req_packet;   // request toward io devices
   ucb_pkt_t rep_packet;   // reply forwarded to tap
   ucb_pkt_t cpu_packet;

   // payload register, loads on the pop from the cpu buffer
   always_ff @(posedge clk) begin
      if (cpu_buf_rd)
         pcx_q <= cpu_buf_dout;
   end

   assign pcx_rq = pcx_q.rq;   // decoded in control

   // pcx request -> ucb request
   always_comb begin
      req_packet.pkt_type = cpu_packet_type;
      req_packet.thr_id   = {1'b0, pcx_q.cpu_id, pcx_q.thr_id};   // ucb thread is one bit wider
      req_packet.buf_id   = UCB_BID_CMP;
      req_packet.size     = pcx_q.size;
      req_packet.addr     = pcx_q.addr;
      req_packet.data     = pcx_q.data;
   end

   // reply carries data only
   always_comb begin
      rep_packet.pkt_type = cpu_packet_type;
      rep_packet.thr_id   = '0;
      rep_packet.buf_id   = UCB_BID_TAP;   // routed back to the debug port
      rep_packet.size     = '0;
      rep_packet.addr     = '0;
      rep_packet.data     = pcx_q.data;
   end

   assign cpu_packet = cpu_packet_is_req ? req_packet : rep_packet;

   // tap has priority over cpu traffic
   assign c2i_packet      = tap_sel ? tap_packet : cpu_packet;
   assign c2i_packet_addr = c2i_packet.addr;   // window decode in control

   // nack for a read outside the io window
   always_comb begin
      if (cpu_packet_type == UCB_IFILL_REQ)
         c2i_rd_nack_packet.pkt_type = UCB_IFILL_NACK;
      else
         c2i_rd_nack_packet.pkt_type = UCB_READ_NACK;
      c2i_rd_nack_packet.thr_id = cpu_packet.thr_id;
      c2i_rd_nack_packet.buf_id = cpu_packet.buf_id;
   end

   // store ack
   always_comb begin
      wr_ack_packet.cpu_mask = 8'b1 << pcx_q.cpu_id;   // one-hot select of the target core
      wr_ack_packet.cpu_id   = pcx_q.cpu_id;
      wr_ack_packet.thr_id   = pcx_q.thr_id;
      wr_ack_packet.blk      = pcx_q.blk;   // block store reflected back
      wr_ack_packet.valid    = 1'b1;
   end

endmodule

// File: rtl/c2i_sctrl.sv
`timescale 1ns/10ps

module c2i_sctrl (
   input  logic                         clk,
   input  logic                         arst_n,
   // tap request
   input  logic                         tap_valid,
   output logic                         tap_ready,
   // cpu buffer head
   input  logic                         cpu_buf_valid,
   output logic                         cpu_buf_rd,
   // from datapath
   input  c2i_pkg::pcx_rq_e             pcx_rq,
   input  logic [c2i_pkg::ADDR_W-1:0]   c2i_packet_addr,
   // to datapath
   output logic                         tap_sel,
   output logic                         cpu_packet_is_req,
   output c2i_pkg::ucb_type_e           cpu_packet_type,
   // output handshakes
   output logic                         ucb_valid,
   input  logic                         ucb_ready,
   output logic                         nack_valid,
   input  logic                         nack_ready,
   output logic                         ack_push,
   input  logic                         ack_ready
);

   import c2i_pkg::*;

   sctrl_state_e state_q, state_d;
   logic         addr_mapped;
   logic         is_store;
   logic         use_ucb;    // converted packet goes to ucb
   logic         use_nack;   // unmapped read

   // request type -> ucb type
   always_comb begin
      case (pcx_rq)
         PCX_LOAD:  cpu_packet_type = UCB_READ_REQ;
         PCX_IFILL: cpu_packet_type = UCB_IFILL_REQ;
         PCX_STORE: cpu_packet_type = UCB_WRITE_REQ;
         PCX_REPLY: cpu_packet_type = UCB_READ_ACK;
         default:   cpu_packet_type = UCB_READ_REQ;
      endcase
   end

   assign cpu_packet_is_req = (pcx_rq != PCX_REPLY);
   assign is_store          = (pcx_rq == PCX_STORE);

   // io window decode, inclusive bounds
   assign addr_mapped = (c2i_packet_addr >= IO_WIN_LO) && (c2i_packet_addr <= IO_WIN_HI);

   // replies always forwarded, address is zero for them
   assign use_ucb  = !cpu_packet_is_req || addr_mapped;
   assign use_nack = !use_ucb && !is_store;   // unmapped store sends nothing

   // handshakes decoded from the registered state
   assign tap_sel    = (state_q == S_TAP);
   assign tap_ready  = tap_sel && ucb_ready;   // tap packet passes straight through
   assign cpu_buf_rd = (state_q == S_LOAD);    // one cycle pop
   assign ucb_valid  = tap_sel || ((state_q == S_ISSUE) && use_ucb);
   assign nack_valid = (state_q == S_ISSUE) && use_nack;
   assign ack_push   = (state_q == S_ACK);

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (tap_valid)            // tap first
               state_d = S_TAP;
            else if (cpu_buf_valid)
               state_d = S_LOAD;
         end
         S_TAP: begin
            if (ucb_ready)
               state_d = S_IDLE;
         end
         S_LOAD: begin
            state_d = S_ISSUE;   // head captured on this edge
         end
         S_ISSUE: begin
            if (use_ucb) begin
               if (ucb_ready)
                  state_d = is_store ? S_ACK : S_IDLE;
            end else if (use_nack) begin
               if (nack_ready)
                  state_d = S_IDLE;
            end else begin
               state_d = S_ACK;   // unmapped store, ack only
            end
         end
         S_ACK: begin
            if (ack_ready)   // hold until ack buffer has room
               state_d = S_IDLE;
         end
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         state_q <= S_IDLE;
      else
         state_q <= state_d;
   end

endmodule

// File: rtl/c2i_top.sv
`timescale 1ns/10ps

module c2i_top (
   input  logic                 clk,
   input  logic                 arst_n,
   // cpu requests in pcx format
   input  logic                 cpu_req_valid,
   output logic                 cpu_req_ready,
   input  c2i_pkg::pcx_pkt_t    cpu_req,
   // debug port packets, already ucb
   input  logic                 tap_req_valid,
   output logic                 tap_req_ready,
   input  c2i_pkg::ucb_pkt_t    tap_req,
   // io devices
   output logic                 ucb_out_valid,
   input  logic                 ucb_out_ready,
   output c2i_pkg::ucb_pkt_t    ucb_out,
   output logic                 nack_out_valid,
   input  logic                 nack_out_ready,
   output c2i_pkg::ucb_nack_t   nack_out,
   // store acks toward cpu
   output logic                 ack_out_valid,
   input  logic                 ack_out_ready,
   output c2i_pkg::cpx_ack_t    ack_out
);

   import c2i_pkg::*;

   pcx_pkt_t          cpu_buf_dout;
   logic              cpu_buf_valid;
   logic              cpu_buf_rd;
   pcx_rq_e           pcx_rq;
   logic [ADDR_W-1:0] c2i_packet_addr;
   logic              tap_sel;
   logic              cpu_packet_is_req;
   ucb_type_e         cpu_packet_type;
   cpx_ack_t          wr_ack_packet;
   logic              ack_push;
   logic              ack_ready;

   c2i_fifo #(.WIDTH(PCX_W), .DEPTH(CPU_BUF_DEPTH)) cpu_buf_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (cpu_req_valid),
      .in_ready  (cpu_req_ready),
      .in_data   (cpu_req),
      .out_valid (cpu_buf_valid),
      .out_ready (cpu_buf_rd),   // popped by the control fsm
      .out_data  (cpu_buf_dout)
   );

   c2i_sdp sdp_i (
      .clk                (clk),
      .cpu_buf_dout       (cpu_buf_dout),
      .cpu_buf_rd         (cpu_buf_rd),
      .tap_packet         (tap_req),
      .tap_sel            (tap_sel),
      .cpu_packet_is_req  (cpu_packet_is_req),
      .cpu_packet_type    (cpu_packet_type),
      .pcx_rq             (pcx_rq),
      .c2i_packet         (ucb_out),
      .c2i_packet_addr    (c2i_packet_addr),
      .c2i_rd_nack_packet (nack_out),
      .wr_ack_packet      (wr_ack_packet)
   );

   c2i_sctrl sctrl_i (
      .clk               (clk),
      .arst_n            (arst_n),
      .tap_valid         (tap_req_valid),
      .tap_ready         (tap_req_ready),
      .cpu_buf_valid     (cpu_buf_valid),
      .cpu_buf_rd        (cpu_buf_rd),
      .pcx_rq            (pcx_rq),
      .c2i_packet_addr   (c2i_packet_addr),
      .tap_sel           (tap_sel),
      .cpu_packet_is_req (cpu_packet_is_req),
      .cpu_packet_type   (cpu_packet_type),
      .ucb_valid         (ucb_out_valid),
      .ucb_ready         (ucb_out_ready),
      .nack_valid        (nack_out_valid),
      .nack_ready        (nack_out_ready),
      .ack_push          (ack_push),
      .ack_ready         (ack_ready)
   );

   // store acks queue up here
   c2i_fifo #(.WIDTH(ACK_W), .DEPTH(ACK_BUF_DEPTH)) ack_buf_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (ack_push),
      .in_ready  (ack_ready),
      .in_data   (wr_ack_packet),
      .out_valid (ack_out_valid),
      .out_ready (ack_out_ready),
      .out_data  (ack_out)
   );

endmodule

// File: sim/c2i_model.svh
`ifndef C2I_MODEL_SVH
`define C2I_MODEL_SVH

// expected outputs, one queue per source and output
ucb_pkt_t  tap_q[$];    // tap packets pass unchanged
ucb_pkt_t  cpu_q[$];    // converted cpu packets
ucb_nack_t nack_q[$];
cpx_ack_t  ack_q[$];

function automatic bit addr_in_window(logic [39:0] addr);
   return (addr >= IO_WIN_LO) && (addr <= IO_WIN_HI);   // inclusive
endfunction

function automatic void expect_tap_request(ucb_pkt_t t);
   tap_q.push_back(t);
endfunction

// pcx packet -> expected ucb, nack and ack
function automatic void expect_cpu_request(pcx_pkt_t p);
   ucb_pkt_t  u;
   ucb_nack_t n;
   cpx_ack_t  a;
   u.thr_id = {1'b0, p.cpu_id, p.thr_id};
   u.buf_id = UCB_BID_CMP;
   u.size   = p.size;
   u.addr   = p.addr;
   u.data   = p.data;
   case (p.rq)
      PCX_LOAD:  u.pkt_type = UCB_READ_REQ;
      PCX_IFILL: u.pkt_type = UCB_IFILL_REQ;
      PCX_STORE: u.pkt_type = UCB_WRITE_REQ;
      default: begin
         u.pkt_type = UCB_READ_ACK;   // reply goes back to tap, no address
         u.thr_id   = '0;
         u.buf_id   = UCB_BID_TAP;
         u.size     = '0;
         u.addr     = '0;
      end
   endcase
   if (p.rq == PCX_REPLY || addr_in_window(p.addr))
      cpu_q.push_back(u);
   else if (p.rq != PCX_STORE) begin
      n.pkt_type = (p.rq == PCX_IFILL) ? UCB_IFILL_NACK : UCB_READ_NACK;
      n.thr_id   = {1'b0, p.cpu_id, p.thr_id};
      n.buf_id   = UCB_BID_CMP;
      nack_q.push_back(n);
   end
   if (p.rq == PCX_STORE) begin   // every store acked, mapped or not
      a.cpu_mask = 8'h01 << p.cpu_id;
      a.cpu_id   = p.cpu_id;
      a.thr_id   = p.thr_id;
      a.blk      = p.blk;
      a.valid    = 1'b1;
      ack_q.push_back(a);
   end
endfunction

`endif

// File: sim/c2i_tb.sv
`timescale 1ns/10ps

module c2i_tb;

   import c2i_pkg::*;

   `include "c2i_model.svh"

   localparam int    N_CPU = 300;
   localparam int    N_TAP = 60;
   localparam real   WD_NS = 400.0 * (N_CPU + N_TAP) * 100.0;   // 400 cycles per packet

   logic clk = 1'b0;
   logic arst_n = 1'b0;
   logic cpu_req_valid = 1'b0, cpu_req_ready;
   logic tap_req_valid = 1'b0, tap_req_ready;
   logic ucb_out_valid, ucb_out_ready = 1'b0;
   logic nack_out_valid, nack_out_ready = 1'b0;
   logic ack_out_valid, ack_out_ready = 1'b0;
   pcx_pkt_t  cpu_req = '0;
   ucb_pkt_t  tap_req = '0;
   ucb_pkt_t  ucb_out, ucb_prev;
   ucb_nack_t nack_out, nack_prev;
   cpx_ack_t  ack_out, ack_prev;
   bit ucb_hold = 0, nack_hold = 0, ack_hold = 0;   // stalled last cycle

   c2i_top dut_i (.*);

   always #50 clk = ~clk;

   task automatic report_mismatch(string name, logic [127:0] got, logic [127:0] exp);
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic report_problem(string msg);
      $display("error: %s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic send_cpu(int n);
      pcx_pkt_t p;
      int       top;
      for (int i = 0; i < n; i++) begin
         p.rq     = pcx_rq_e'($urandom_range(0, 3));
         p.cpu_id = $urandom_range(0, 7);
         p.thr_id = $urandom_range(0, 3);
         p.blk    = $urandom_range(0, 1);
         p.size   = $urandom_range(0, 7);
         p.data   = {$urandom, $urandom};
         top      = ($urandom_range(0, 99) < 70) ? 2 : 3 * $urandom_range(0, 1);   // ~70% mapped
         p.addr   = {top[1:0], 6'($urandom_range(0, 63)), $urandom};
         cpu_req       = p;
         cpu_req_valid = 1'b1;
         do @(negedge clk); while (!cpu_req_ready);
         expect_cpu_request(p);    // transfer on the coming edge
         @(posedge clk);
         #10;
         cpu_req_valid = 1'b0;
         if ($urandom_range(0, 3) == 0) begin   // idle gap
            @(posedge clk);
            #10;
         end
      end
   endtask

   task automatic send_tap(int n);
      ucb_pkt_t t;
      for (int i = 0; i < n; i++) begin
         repeat ($urandom_range(1, 12)) @(posedge clk);
         #10;
         t.pkt_type = $urandom_range(0, 15);
         t.thr_id   = $urandom_range(0, 63);
         t.buf_id   = UCB_BID_TAP;
         t.size     = $urandom_range(0, 7);
         t.addr     = {$urandom_range(0, 255), $urandom};
         t.data     = {$urandom, $urandom};
         tap_req       = t;
         tap_req_valid = 1'b1;
         expect_tap_request(t);   // valid stays up until taken
         do @(negedge clk); while (!tap_req_ready);
         @(posedge clk);
         #10;
         tap_req_valid = 1'b0;
      end
   endtask

   // random back-pressure, ready high ~60%
   initial begin
      forever begin
         @(posedge clk);
         #10;
         ucb_out_ready  = ($urandom_range(0, 99) < 60);
         nack_out_ready = ($urandom_range(0, 99) < 60);
         ack_out_ready  = ($urandom_range(0, 99) < 60);
      end
   end

   // output monitor, sampled mid-cycle where everything is settled
   always @(negedge clk) begin
      if (!arst_n) begin
         assert (!ucb_out_valid && !nack_out_valid && !ack_out_valid)
            else report_problem("output valid high during reset");
      end else begin
         if (ucb_hold) begin   // stalled packet must stay put
            assert (ucb_out_valid) else report_problem("ucb_out_valid dropped before transfer");
            assert (ucb_out == ucb_prev) else report_mismatch("ucb_out", ucb_out, ucb_prev);
         end
         if (nack_hold) begin
            assert (nack_out_valid) else report_problem("nack_out_valid dropped before transfer");
            assert (nack_out == nack_prev) else report_mismatch("nack_out", nack_out, nack_prev);
         end
         if (ack_hold) begin
            assert (ack_out_valid) else report_problem("ack_out_valid dropped before transfer");
            assert (ack_out == ack_prev) else report_mismatch("ack_out", ack_out, ack_prev);
         end
         if (ucb_out_valid && ucb_out_ready) begin
            if (tap_q.size() > 0 && ucb_out == tap_q[0])
               void'(tap_q.pop_front());
            else begin
               assert (cpu_q.size() > 0) else report_problem("unexpected packet on ucb_out");
               assert (ucb_out == cpu_q[0]) else report_mismatch("ucb_out", ucb_out, cpu_q[0]);
               void'(cpu_q.pop_front());
            end
         end
         if (nack_out_valid && nack_out_ready) begin
            assert (nack_q.size() > 0) else report_problem("unexpected nack on nack_out");
            assert (nack_out == nack_q[0]) else report_mismatch("nack_out", nack_out, nack_q[0]);
            void'(nack_q.pop_front());
         end
         if (ack_out_valid && ack_out_ready) begin
            assert (ack_q.size() > 0) else report_problem("unexpected ack on ack_out");
            assert (ack_out == ack_q[0]) else report_mismatch("ack_out", ack_out, ack_q[0]);
            void'(ack_q.pop_front());
         end
         ucb_hold  = ucb_out_valid && !ucb_out_ready;
         nack_hold = nack_out_valid && !nack_out_ready;
         ack_hold  = ack_out_valid && !ack_out_ready;
         ucb_prev  = ucb_out;
         nack_prev = nack_out;
         ack_prev  = ack_out;
      end
   end

   // watchdog
   initial begin
      #(WD_NS);
      $display("error: timeout, outputs stopped before all packets came out");
      $display("Simulation failed");
      $fatal(1);
   end

   initial begin
      void'($urandom(32'h3a86));
      repeat (5) @(posedge clk);
      #10;
      arst_n = 1'b1;
      @(negedge clk);   // first cycle out of reset, nothing pending yet
      assert (!ucb_out_valid && !nack_out_valid && !ack_out_valid)
         else report_problem("output valid high right after reset");
      @(posedge clk);
      #10;
      fork
         send_cpu(N_CPU);
         send_tap(N_TAP);
      join
      wait (tap_q.size() == 0 && cpu_q.size() == 0 && nack_q.size() == 0 && ack_q.size() == 0);
      repeat (20) @(negedge clk);   // drain, the monitor flags anything extra
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: files.f
+incdir+sim
rtl/c2i_pkg.sv
rtl/c2i_fifo.sv
rtl/c2i_sdp.sv
rtl/c2i_sctrl.sv
rtl/c2i_top.sv
sim/c2i_tb.sv

// File: Bender.yml
package:
  name: c2i

sources:
  - rtl/c2i_pkg.sv
  - rtl/c2i_fifo.sv
  - rtl/c2i_sdp.sv
  - rtl/c2i_sctrl.sv
  - rtl/c2i_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/c2i_tb.sv
